// File: drum_vis.f
+incdir+verilog
verilog/drum_vis_pkg.sv
verilog/noise_lfsr.sv
verilog/circle_hollow.sv
verilog/square_noise.sv
verilog/hex_hollow.sv
verilog/intensity_mix.sv
verilog/dry_gen.sv
verif/tb_dry_gen.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dry_gen testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -Wno-fatal \
  --top-module tb_dry_gen \
  -f drum_vis.f \
  -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_dry_gen" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi

exit 0

// File: verif/tb_dry_gen.sv
`timescale 1ns/1ns
`include "drum_vis_defs.svh"

module tb_dry_gen;

  localparam int PIXELS = 300;
  localparam int TIMEOUT_CYCLES = 6 * 400 + 100;

  // shape constants worked out from the geometry
  localparam int BD_RSQ   = `DV_BD_RADIUS * `DV_BD_RADIUS;
  localparam int BD_SHIFT = $clog2(BD_RSQ) - 8;
  localparam int BD_OFFS  = (255 - ((BD_RSQ - 1) >> BD_SHIFT)) & 255;
  localparam int SD_HALF  = `DV_SD_WIDTH / 2;
  localparam int SD_SHIFT = 9 - $clog2(`DV_SD_WIDTH);
  localparam int SD_OFFS  = (255 - ((SD_HALF - 1) << SD_SHIFT)) & 255;
  localparam int T1_SHIFT = $clog2(`DV_T1_HEIGHT) - 6;
  localparam int T1_OFFS  = (255 - ((8 * `DV_T1_HEIGHT - 1) >> T1_SHIFT)) & 255;

  logic                 clk;
  logic                 rst;
  drum_vis_pkg::h_pos_t h_count;
  drum_vis_pkg::v_pos_t v_count;
  drum_vis_pkg::level_t bd_level, sd_level, t1_level;
  drum_vis_pkg::level_t intensity;

  logic [31:0]         rng;
  drum_vis_pkg::lfsr_t model_lfsr; // mirrors the DUT noise state
  int pipe[$];                     // expected values in flight
  int edges;
  int cycle_count = 0;
  int checks, errors, tests_ok, tests_bad;

  dry_gen UUT (
    .clk       (clk),
    .rst       (rst),
    .h_count   (h_count),
    .v_count   (v_count),
    .bd_level  (bd_level),
    .sd_level  (sd_level),
    .t1_level  (t1_level),
    .intensity (intensity)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(input int lo, input int span, output int val);
    rng = xorshift(rng);
    val = lo + int'(rng[23:8]) % span;
  endtask

  function automatic drum_vis_pkg::lfsr_t lfsr_step(input drum_vis_pkg::lfsr_t s);
    if (s[31]) return (s << 1) ^ `DV_LFSR_POLY;
    return s << 1;
  endfunction

  function automatic int scramble(input drum_vis_pkg::lfsr_t s);
    return int'({s[0], s[5], s[3], s[7], s[1], s[4], s[6], s[2]});
  endfunction

  function automatic int abs_diff(input int a, input int b);
    return a > b ? a - b : b - a;
  endfunction

  function automatic int circle_level(input int h, input int v, input int loud);
    int dx, dy, sq, shape;
    dx = abs_diff(h, `DV_BD_CX);
    dy = abs_diff(v, `DV_BD_CY);
    sq = (dx % 256) * (dx % 256) + (dy % 256) * (dy % 256);
    if (dx >= `DV_BD_RADIUS || dy >= `DV_BD_RADIUS || sq >= BD_RSQ) return 0;
    shape = ((sq >> BD_SHIFT) + BD_OFFS) & 255;
    return (shape * loud) >> 8;
  endfunction

  function automatic int square_level(input int h, input int v, input int loud,
                                      input int noise);
    int dx, dy, dmax, edge_v, shape;
    dx = abs_diff(h, `DV_SD_CX);
    dy = abs_diff(v, `DV_SD_CY);
    if (dx >= SD_HALF || dy >= SD_HALF) return 0;
    dmax = dx > dy ? dx : dy;
    edge_v = (((dmax << SD_SHIFT) & 255) + SD_OFFS) & 255;
    shape = edge_v > noise ? edge_v : noise;
    return (shape * loud) >> 8;
  endfunction

  function automatic int hex_level(input int h, input int v, input int loud);
    int dx, dy, a, b, c, m;
    dx = abs_diff(h, `DV_T1_CX);
    dy = abs_diff(v, `DV_T1_CY);
    a = 8 * dy;
    b = 4 * dy + 7 * dx;
    c = abs_diff(4 * dy, 7 * dx);
    m = a > b ? a : b;
    m = m > c ? m : c;
    if (m * 64 >= `DV_T1_HEIGHT * loud) return 0; // hexagon grows with loudness
    return ((m >> T1_SHIFT) + T1_OFFS) & 255;
  endfunction

  function automatic int pixel_model(input int h, input int v, input int bd, input int sd,
                                     input int t1, input int noise);
    int sum;
    sum = circle_level(h, v, bd) + square_level(h, v, sd, noise) + hex_level(h, v, t1);
    if (sum > `DV_LEVEL_MAX) sum = `DV_LEVEL_MAX;
    return sum;
  endfunction

  task automatic compare_intensity(input int expected);
    checks = checks + 1;
    if (intensity !== drum_vis_pkg::level_t'(expected)) begin
      errors = errors + 1;
      $display("[FAIL] %0t ns intensity expected %0d got %0d", $time, expected, intensity);
    end
  endtask

  task automatic drive(input int h, input int v, input int bd, input int sd, input int t1);
    h_count  <= drum_vis_pkg::h_pos_t'(h);
    v_count  <= drum_vis_pkg::v_pos_t'(v);
    bd_level <= drum_vis_pkg::level_t'(bd);
    sd_level <= drum_vis_pkg::level_t'(sd);
    t1_level <= drum_vis_pkg::level_t'(t1);
  endtask

  // one clock edge: check the output, then feed the model the sampled pixel
  task automatic step_check;
    int exp_val;
    @(posedge clk);
    edges = edges + 1;
    if (rst) begin
      model_lfsr = `DV_LFSR_SEED;
      pipe.delete();
      if (edges > 1) compare_intensity(0);
    end else begin
      if (pipe.size() == 4) compare_intensity(pipe.pop_front());
      else compare_intensity(0); // pipeline still empty after reset
      model_lfsr = lfsr_step(model_lfsr);
      exp_val = pixel_model(int'(h_count), int'(v_count), int'(bd_level),
                            int'(sd_level), int'(t1_level), scramble(model_lfsr));
      pipe.push_back(exp_val);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    if (errors == err_start) begin
      tests_ok = tests_ok + 1;
      $display("test %s: ok", name);
    end else begin
      tests_bad = tests_bad + 1;
      $display("test %s: %0d mismatches", name, errors - err_start);
    end
  endtask

  task automatic reset_test;
    int i, h, v, bd, sd, t1, err_start;
    err_start = errors;
    for (i = 0; i < 14; i++) begin
      step_check();
      draw(0, 2048, h);
      draw(0, 1024, v);
      draw(0, 256, bd);
      draw(0, 256, sd);
      draw(0, 256, t1);
      drive(h, v, bd, sd, t1);
      if (i == 9) rst <= 1'b0; // 10 cycles of reset
    end
    report_test("reset", err_start);
  endtask

  task automatic run_test(input string name, input int kind);
    int i, h, v, bd, sd, t1, z, err_start;
    err_start = errors;
    for (i = 0; i < PIXELS; i++) begin
      step_check();
      bd = 0;
      sd = 0;
      t1 = 0;
      case (kind)
        1: begin
          draw(340, 601, h);
          draw(150, 601, v);
          draw(0, 256, bd);
        end
        2: begin
          draw(272, 257, h);
          draw(322, 257, v);
          draw(0, 256, sd);
        end
        3: begin
          draw(640, 321, h);
          draw(210, 321, v);
          draw(0, 256, t1);
          draw(0, 8, z);
          if (z == 0) t1 = 0; // silent tom now and then
        end
        4: begin
          draw(400, 401, h);
          draw(350, 201, v);
          bd = 255;
          sd = 255;
          t1 = 255;
        end
        default: begin
          draw(1000, 1048, h);
          draw(0, 1024, v);
          draw(0, 256, bd);
          draw(0, 256, sd);
          draw(0, 256, t1);
        end
      endcase
      drive(h, v, bd, sd, t1);
    end
    // drain so every pixel of this test gets checked
    for (i = 0; i < 5; i++) begin
      step_check();
      drive(0, 0, 0, 0, 0);
    end
    report_test(name, err_start);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    h_count = '0;
    v_count = '0;
    bd_level = '0;
    sd_level = '0;
    t1_level = '0;
    rng = 32'd97876;
    model_lfsr = `DV_LFSR_SEED;
    edges = 0;
    checks = 0;
    errors = 0;
    tests_ok = 0;
    tests_bad = 0;

    reset_test();
    run_test("bass_drum", 1);
    run_test("snare", 2);
    run_test("tom1", 3);
    run_test("overlap", 4);
    run_test("far_field", 5);

    $display("tests ok %0d, bad %0d, checks %0d, mismatches %0d",
             tests_ok, tests_bad, checks, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: verilog/circle_hollow.sv
`timescale 1ns/1ns
`include "drum_vis_defs.svh"

// bass drum ring, brightest at the rim, 3 cycles
module circle_hollow #(
  parameter int RADIUS   = `DV_BD_RADIUS,
  parameter int CENTER_X = `DV_BD_CX,
  parameter int CENTER_Y = `DV_BD_CY
) (
  input  logic                  clk,
  input  logic                  rst,
  input  drum_vis_pkg::h_pos_t  h_count,
  input  drum_vis_pkg::v_pos_t  v_count,
  input  drum_vis_pkg::level_t  inst_level,
  output drum_vis_pkg::level_t  level
);

  localparam int RAD_SQ = RADIUS * RADIUS;
  localparam int SHFT = $clog2(RAD_SQ) - 8;
  localparam drum_vis_pkg::level_t OFFSET =
    drum_vis_pkg::level_t'(`DV_LEVEL_MAX - ((RAD_SQ - 1) >> SHFT));
  localparam drum_vis_pkg::h_pos_t CX = drum_vis_pkg::h_pos_t'(CENTER_X);
  localparam drum_vis_pkg::v_pos_t CY = drum_vis_pkg::v_pos_t'(CENTER_Y);

  drum_vis_pkg::h_pos_t  x_dist, x_q;
  drum_vis_pkg::v_pos_t  y_dist, y_q;
  drum_vis_pkg::rad_sq_t x_sq, y_sq, rad_sq_q;
  drum_vis_pkg::level_t  loud_q1, loud_q2;
  drum_vis_pkg::level_t  shape_q;
  logic [2*`DV_LEVEL_W-1:0] scaled;

  assign x_dist = h_count > CX ? h_count - CX : CX - h_count;
  assign y_dist = v_count > CY ? v_count - CY : CY - v_count;
  assign x_sq = drum_vis_pkg::rad_sq_t'(x_dist[7:0]) * drum_vis_pkg::rad_sq_t'(x_dist[7:0]);
  assign y_sq = drum_vis_pkg::rad_sq_t'(y_dist[7:0]) * drum_vis_pkg::rad_sq_t'(y_dist[7:0]);
  assign scaled = {8'b0, shape_q} * {8'b0, loud_q2};

  always_ff @(posedge clk) begin
    if (rst) begin
      x_q      <= '0;
      y_q      <= '0;
      rad_sq_q <= '0;
      loud_q1  <= '0;
      loud_q2  <= '0;
      shape_q  <= '0;
      level    <= '0;
    end else begin
      x_q      <= x_dist;
      y_q      <= y_dist;
      rad_sq_q <= x_sq + y_sq;
      loud_q1  <= inst_level;
      loud_q2  <= loud_q1;
      if (x_q >= RADIUS || y_q >= RADIUS || rad_sq_q >= RAD_SQ) begin
        shape_q <= '0; // outside the ring
      end else begin
        shape_q <= drum_vis_pkg::level_t'(rad_sq_q >> SHFT) + OFFSET;
      end
      level    <= scaled[15:8];
    end
  end

endmodule

// File: verilog/drum_vis_defs.svh
`ifndef DRUM_VIS_DEFS_SVH
`define DRUM_VIS_DEFS_SVH

// pixel and level widths
`define DV_H_W     11
`define DV_V_W     10
`define DV_LEVEL_W 8
`define DV_LFSR_W  32

`define DV_LFSR_POLY 32'h04C1_1DB7 // galois feedback mask
`define DV_LFSR_SEED 32'hFFFF_FFFF

`define DV_LEVEL_MAX 255

// default shape geometry
`define DV_BD_RADIUS 256
`define DV_BD_CX     640
`define DV_BD_CY     450
`define DV_SD_WIDTH  192
`define DV_SD_CX     400
`define DV_SD_CY     450
`define DV_T1_HEIGHT 256
`define DV_T1_CX     800
`define DV_T1_CY     370

`endif

// File: verilog/drum_vis_pkg.sv
`include "drum_vis_defs.svh"

package drum_vis_pkg;

  // screen coordinates and distances
  typedef logic [`DV_H_W-1:0] h_pos_t;
  typedef logic [`DV_V_W-1:0] v_pos_t;

  typedef logic [`DV_LEVEL_W-1:0] level_t; // brightness / loudness
  typedef logic [`DV_LFSR_W-1:0] lfsr_t;

  // sum of two 8 bit squares
  typedef logic [16:0] rad_sq_t;

  typedef logic [13:0] hex_dist_t; // scaled hexagon axis distance

endpackage

// File: verilog/dry_gen.sv
`timescale 1ns/1ns
`include "drum_vis_defs.svh"

// pixel brightness, 4 cycles after the pixel is sampled
module dry_gen (
  input  logic                  clk,
  input  logic                  rst,
  input  drum_vis_pkg::h_pos_t  h_count,
  input  drum_vis_pkg::v_pos_t  v_count,
  input  drum_vis_pkg::level_t  bd_level,
  input  drum_vis_pkg::level_t  sd_level,
  input  drum_vis_pkg::level_t  t1_level,
  output drum_vis_pkg::level_t  intensity
);

  drum_vis_pkg::level_t noise;
  drum_vis_pkg::level_t bd_shape, sd_shape, t1_shape;

  noise_lfsr u_noise (
    .clk   (clk),
    .rst   (rst),
    .noise (noise)
  );

  // bass drum
  circle_hollow #(
    .RADIUS   (`DV_BD_RADIUS),
    .CENTER_X (`DV_BD_CX),
    .CENTER_Y (`DV_BD_CY)
  ) u_bd_circle (
    .clk        (clk),
    .rst        (rst),
    .h_count    (h_count),
    .v_count    (v_count),
    .inst_level (bd_level),
    .level      (bd_shape)
  );

  square_noise #(
    .WIDTH    (`DV_SD_WIDTH),
    .CENTER_X (`DV_SD_CX),
    .CENTER_Y (`DV_SD_CY)
  ) u_sd_square (
    .clk        (clk),
    .rst        (rst),
    .h_count    (h_count),
    .v_count    (v_count),
    .noise      (noise),
    .inst_level (sd_level),
    .level      (sd_shape)
  );

  hex_hollow #(
    .HEIGHT   (`DV_T1_HEIGHT),
    .CENTER_X (`DV_T1_CX),
    .CENTER_Y (`DV_T1_CY)
  ) u_t1_hex (
    .clk        (clk),
    .rst        (rst),
    .h_count    (h_count),
    .v_count    (v_count),
    .inst_level (t1_level),
    .level      (t1_shape)
  );

  intensity_mix u_mix (
    .clk       (clk),
    .rst       (rst),
    .bd_level  (bd_shape),
    .sd_level  (sd_shape),
    .t1_level  (t1_shape),
    .intensity (intensity)
  );

endmodule

// File: verilog/hex_hollow.sv
`timescale 1ns/1ns
`include "drum_vis_defs.svh"

// tom hexagon, size follows loudness, 3 cycles
module hex_hollow #(
  parameter int HEIGHT   = `DV_T1_HEIGHT,
  parameter int CENTER_X = `DV_T1_CX,
  parameter int CENTER_Y = `DV_T1_CY
) (
  input  logic                  clk,
  input  logic                  rst,
  input  drum_vis_pkg::h_pos_t  h_count,
  input  drum_vis_pkg::v_pos_t  v_count,
  input  drum_vis_pkg::level_t  inst_level,
  output drum_vis_pkg::level_t  level
);

  localparam int SHFT = $clog2(HEIGHT) - 6;
  localparam drum_vis_pkg::level_t OFFSET =
    drum_vis_pkg::level_t'(`DV_LEVEL_MAX - ((8 * HEIGHT - 1) >> SHFT));
  localparam drum_vis_pkg::h_pos_t CX = drum_vis_pkg::h_pos_t'(CENTER_X);
  localparam drum_vis_pkg::v_pos_t CY = drum_vis_pkg::v_pos_t'(CENTER_Y);

  drum_vis_pkg::h_pos_t    x_dist;
  drum_vis_pkg::v_pos_t    y_dist;
  drum_vis_pkg::hex_dist_t eight_y, four_y, seven_x;
  drum_vis_pkg::hex_dist_t ns_q, ne_q, se_q; // the three edge normals
  drum_vis_pkg::hex_dist_t max_ab, max_q;
  drum_vis_pkg::level_t    loud_q1, loud_q2;

  assign x_dist = h_count > CX ? h_count - CX : CX - h_count;
  assign y_dist = v_count > CY ? v_count - CY : CY - v_count;
  assign eight_y = drum_vis_pkg::hex_dist_t'(y_dist) << 3;
  assign four_y = drum_vis_pkg::hex_dist_t'(y_dist) << 2;
  assign seven_x = drum_vis_pkg::hex_dist_t'(x_dist) * 14'd7; // ~4*sqrt(3)

  assign max_ab = ns_q > ne_q ? ns_q : ne_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ns_q    <= '0;
      ne_q    <= '0;
      se_q    <= '0;
      loud_q1 <= '0;
      loud_q2 <= '0;
      max_q   <= '0;
      level   <= '0;
    end else begin
      ns_q    <= eight_y;
      ne_q    <= four_y + seven_x;
      se_q    <= four_y >= seven_x ? four_y - seven_x : seven_x - four_y;
      loud_q1 <= inst_level;
      loud_q2 <= loud_q1;
      max_q   <= max_ab > se_q ? max_ab : se_q;
      // louder hit draws a bigger hexagon
      if ({max_q, 6'b0} >= HEIGHT * loud_q2) begin
        level <= '0;
      end else begin
        level <= drum_vis_pkg::level_t'(max_q >> SHFT) + OFFSET;
      end
    end
  end

endmodule

// File: verilog/intensity_mix.sv
`timescale 1ns/1ns
`include "drum_vis_defs.svh"

module intensity_mix (
  input  logic                  clk,
  input  logic                  rst,
  input  drum_vis_pkg::level_t  bd_level,
  input  drum_vis_pkg::level_t  sd_level,
  input  drum_vis_pkg::level_t  t1_level,
  output drum_vis_pkg::level_t  intensity
);

  logic [`DV_LEVEL_W+1:0] sum; // room for three full levels
  drum_vis_pkg::level_t   clamped;

  assign sum = {2'b0, bd_level} + {2'b0, sd_level} + {2'b0, t1_level};

  // saturate instead of wrapping
  assign clamped = sum > `DV_LEVEL_MAX ? drum_vis_pkg::level_t'(`DV_LEVEL_MAX)
                                       : sum[`DV_LEVEL_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      intensity <= '0;
    end else begin
      intensity <= clamped;
    end
  end

endmodule

// File: verilog/noise_lfsr.sv
`timescale 1ns/1ns
`include "drum_vis_defs.svh"

module noise_lfsr (
  input  logic                  clk,
  input  logic                  rst,
  output drum_vis_pkg::level_t  noise
);

  drum_vis_pkg::lfsr_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= `DV_LFSR_SEED;
    end else begin
      // galois step, feedback when top bit falls out
      state <= (state << 1) ^ (state[`DV_LFSR_W-1] ? `DV_LFSR_POLY : '0);
    end
  end

  // scrambled low byte so adjacent pixels look less correlated
  assign noise = {state[0], state[5], state[3], state[7],
                  state[1], state[4], state[6], state[2]};

endmodule

// File: verilog/square_noise.sv
`timescale 1ns/1ns
`include "drum_vis_defs.svh"

// snare square filled with noise, 3 cycles
module square_noise #(
  parameter int WIDTH    = `DV_SD_WIDTH,
  parameter int CENTER_X = `DV_SD_CX,
  parameter int CENTER_Y = `DV_SD_CY
) (
  input  logic                  clk,
  input  logic                  rst,
  input  drum_vis_pkg::h_pos_t  h_count,
  input  drum_vis_pkg::v_pos_t  v_count,
  input  drum_vis_pkg::level_t  noise,
  input  drum_vis_pkg::level_t  inst_level,
  output drum_vis_pkg::level_t  level
);

  localparam int SHFT = 9 - $clog2(WIDTH);
  localparam int HALF = WIDTH >> 1;
  localparam drum_vis_pkg::level_t OFFSET =
    drum_vis_pkg::level_t'(`DV_LEVEL_MAX - ((HALF - 1) << SHFT));
  localparam drum_vis_pkg::h_pos_t CX = drum_vis_pkg::h_pos_t'(CENTER_X);
  localparam drum_vis_pkg::v_pos_t CY = drum_vis_pkg::v_pos_t'(CENTER_Y);

  drum_vis_pkg::h_pos_t x_dist, x_q;
  drum_vis_pkg::v_pos_t y_dist, y_q;
  drum_vis_pkg::h_pos_t max_dist;
  drum_vis_pkg::level_t edge_val;
  drum_vis_pkg::level_t loud_q1, loud_q2;
  drum_vis_pkg::level_t shape_q;
  logic [2*`DV_LEVEL_W-1:0] scaled;

  assign x_dist = h_count > CX ? h_count - CX : CX - h_count;
  assign y_dist = v_count > CY ? v_count - CY : CY - v_count;

  // chebyshev distance, ramps up toward the edge
  assign max_dist = x_q < drum_vis_pkg::h_pos_t'(y_q) ? drum_vis_pkg::h_pos_t'(y_q) : x_q;
  assign edge_val = drum_vis_pkg::level_t'(max_dist << SHFT) + OFFSET;
  assign scaled = {8'b0, shape_q} * {8'b0, loud_q2};

  always_ff @(posedge clk) begin
    if (rst) begin
      x_q     <= '0;
      y_q     <= '0;
      loud_q1 <= '0;
      loud_q2 <= '0;
      shape_q <= '0;
      level   <= '0;
    end else begin
      x_q     <= x_dist;
      y_q     <= y_dist;
      loud_q1 <= inst_level;
      loud_q2 <= loud_q1;
      if (x_q < HALF && y_q < HALF) begin
        shape_q <= edge_val > noise ? edge_val : noise; // noise sets the floor
      end else begin
        shape_q <= '0;
      end
      level   <= scaled[15:8];
    end
  end

endmodule
